// ==== logic/lsq_pkg.sv ====
package lsq_pkg;

  // address and cache geometry
  parameter int ADDR_W      = 32;
  parameter int BANKS       = 8;
  parameter int BANK_BYTES  = 4;
  parameter int BANK_W      = 3;  // log2 of BANKS
  parameter int OFS_W       = 2;  // log2 of BANK_BYTES
  parameter int LINE_W      = ADDR_W - BANK_W - OFS_W;

  parameter int STORE_BYTES = 8;
  parameter int STORE_W     = STORE_BYTES * 8;

  // an 8 byte store at offset 3 reaches into a third bank
  parameter int LANE_BANKS  = 3;
  parameter int LANE_BYTES  = LANE_BANKS * BANK_BYTES;
  parameter int LANE_W      = LANE_BYTES * 8;

  // log2 of the byte count
  typedef logic [1:0] size_t;

  typedef union packed {
    logic [ADDR_W-1:0] byte_addr;
    struct packed {
      logic [LINE_W-1:0] line;
      logic [BANK_W-1:0] bank;
      logic [OFS_W-1:0]  ofs;
    } fld;
  } store_addr_u;

  typedef logic [BANKS-1:0]      bank_mask_t;  // one bit per bank written
  typedef logic [BANK_BYTES-1:0] byte_en_t;
  typedef logic [STORE_W-1:0]    store_data_t;
  typedef logic [LANE_W-1:0]     lane_data_t;

endpackage

// ==== logic/store_queue.sv ====
module store_queue #(
  parameter int STQ_DEPTH = 16,
  localparam int TAG_W = $clog2(STQ_DEPTH)
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sta_en,
  input  lsq_pkg::store_addr_u          sta_addr,
  input  lsq_pkg::size_t                sta_size,
  input  logic                          std_en,
  input  logic [TAG_W-1:0]              std_tag,
  input  lsq_pkg::store_data_t          std_data,
  input  logic [1:0]                    pop_cnt,
  output logic [TAG_W-1:0]              alloc_tag,
  output logic                          stq_full,
  output logic [1:0]                    head_valid,
  output lsq_pkg::store_addr_u [1:0]    head_addr,
  output lsq_pkg::size_t [1:0]          head_size,
  output lsq_pkg::store_data_t [1:0]    head_data
);

  // entry payload
  lsq_pkg::store_addr_u addr_mem [STQ_DEPTH];
  lsq_pkg::size_t       size_mem [STQ_DEPTH];
  lsq_pkg::store_data_t data_mem [STQ_DEPTH];

  logic [STQ_DEPTH-1:0] ready;  // data written
  logic [TAG_W-1:0]     head;
  logic [TAG_W-1:0]     head_next;
  logic [TAG_W-1:0]     tail;
  logic [TAG_W:0]       count;
  logic                 do_alloc;

  // pointer advance with wrap at the queue depth
  function automatic logic [TAG_W-1:0] ptr_add(input logic [TAG_W-1:0] ptr,
                                               input logic [1:0] inc);
    logic [TAG_W:0] sum;
    sum = {1'b0, ptr} + (TAG_W+1)'(inc);
    if (sum >= (TAG_W+1)'(STQ_DEPTH)) begin
      sum = sum - (TAG_W+1)'(STQ_DEPTH);
    end
    return sum[TAG_W-1:0];
  endfunction

  assign stq_full  = count == (TAG_W+1)'(STQ_DEPTH);
  assign do_alloc  = sta_en & ~stq_full;
  assign alloc_tag = tail;
  assign head_next = ptr_add(head, 2'd1);

  assign head_valid[0] = (count != '0) & ready[head];
  assign head_valid[1] = (count > (TAG_W+1)'(1)) & ready[head_next];

  assign head_addr[0] = addr_mem[head];
  assign head_addr[1] = addr_mem[head_next];
  assign head_size[0] = size_mem[head];
  assign head_size[1] = size_mem[head_next];
  assign head_data[0] = data_mem[head];
  assign head_data[1] = data_mem[head_next];

  always_ff @(posedge clk) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      ready <= '0;
    end else begin
      if (do_alloc) begin
        tail        <= ptr_add(tail, 2'd1);
        ready[tail] <= 1'b0;  // waits for its data
      end
      // a data write to the entry just allocated still wins
      if (std_en) begin
        ready[std_tag] <= 1'b1;
      end
      head  <= ptr_add(head, pop_cnt);
      count <= count + (TAG_W+1)'(do_alloc) - (TAG_W+1)'(pop_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      addr_mem[tail] <= sta_addr;
      size_mem[tail] <= sta_size;
    end
    if (std_en) begin
      data_mem[std_tag] <= std_data;
    end
  end

endmodule

// ==== logic/bank_enables.sv ====
module bank_enables (
  input  lsq_pkg::store_addr_u              addr,
  input  lsq_pkg::size_t                    size,
  output logic [lsq_pkg::BANK_W-1:0]        bank_bgn,
  output logic [lsq_pkg::BANK_W-1:0]        bank_end,
  output lsq_pkg::bank_mask_t               bank_mask,
  output lsq_pkg::byte_en_t                 bgn_ben,
  output lsq_pkg::byte_en_t                 end_ben
);

  // byte positions counted from the start of the begin bank
  logic [lsq_pkg::OFS_W+1:0]  nbytes;
  logic [lsq_pkg::OFS_W+1:0]  first;
  logic [lsq_pkg::OFS_W+1:0]  last;
  logic [lsq_pkg::OFS_W+1:0]  pos;
  logic [1:0]                 span;  // banks past the begin bank
  logic [lsq_pkg::BANK_W-1:0] idx;

  always_comb begin
    nbytes   = (lsq_pkg::OFS_W+2)'(1) << size;
    first    = {2'b00, addr.fld.ofs};
    last     = first + nbytes - (lsq_pkg::OFS_W+2)'(1);
    span     = last[lsq_pkg::OFS_W+1:lsq_pkg::OFS_W];
    bank_bgn = addr.fld.bank;
    bank_end = bank_bgn + lsq_pkg::BANK_W'(span);  // wraps mod BANKS

    bank_mask = '0;
    for (int j = 0; j < lsq_pkg::LANE_BANKS; j++) begin
      idx = bank_bgn + lsq_pkg::BANK_W'(j);
      if (2'(j) <= span) bank_mask[idx] = 1'b1;
    end

    // same test for both edges, only the bank position differs
    for (int b = 0; b < lsq_pkg::BANK_BYTES; b++) begin
      pos        = {2'b00, lsq_pkg::OFS_W'(b)};
      bgn_ben[b] = (pos >= first) && (pos <= last);
      pos        = {span, lsq_pkg::OFS_W'(b)};
      end_ben[b] = (pos >= first) && (pos <= last);
    end
  end

endmodule

// ==== logic/store_data_align.sv ====
module store_data_align (
  input  lsq_pkg::store_data_t  data,
  input  lsq_pkg::store_addr_u  addr,
  output lsq_pkg::lane_data_t   lane_data
);

  logic [lsq_pkg::OFS_W-1:0] ofs;
  logic [7:0]                 src_byte;
  int                         src;

  assign ofs = addr.fld.ofs;

  // lane k takes store byte k - ofs
  always_comb begin
    lane_data = '0;
    for (int k = 0; k < lsq_pkg::LANE_BYTES; k++) begin
      src      = k - int'(ofs);
      src_byte = 8'h00;
      if (src >= 0 && src < lsq_pkg::STORE_BYTES) begin
        src_byte = data[src*8 +: 8];
      end
      lane_data[k*8 +: 8] = src_byte;  // unused lanes stay zero
    end
  end

endmodule

// ==== logic/store_issue.sv ====
module store_issue (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cache_hold,
  input  logic [1:0]                        head_valid,
  input  lsq_pkg::store_addr_u [1:0]        head_addr,
  input  lsq_pkg::size_t [1:0]              head_size,
  input  lsq_pkg::store_data_t [1:0]        head_data,
  output logic [1:0]                        pop_cnt,
  output logic                              st0_en,
  output lsq_pkg::store_addr_u              st0_addr,
  output logic [lsq_pkg::BANK_W-1:0]        st0_bank_bgn,
  output logic [lsq_pkg::BANK_W-1:0]        st0_bank_end,
  output lsq_pkg::byte_en_t                 st0_bgn_ben,
  output lsq_pkg::byte_en_t                 st0_end_ben,
  output lsq_pkg::lane_data_t               st0_data,
  output logic                              st1_en,
  output lsq_pkg::store_addr_u              st1_addr,
  output logic [lsq_pkg::BANK_W-1:0]        st1_bank_bgn,
  output logic [lsq_pkg::BANK_W-1:0]        st1_bank_end,
  output lsq_pkg::byte_en_t                 st1_bgn_ben,
  output lsq_pkg::byte_en_t                 st1_end_ben,
  output lsq_pkg::lane_data_t               st1_data
);

  logic                        hold_reg;
  logic [1:0]                  issue;
  logic [lsq_pkg::BANK_W-1:0]  bank_bgn [2];
  logic [lsq_pkg::BANK_W-1:0]  bank_end [2];
  lsq_pkg::bank_mask_t         bank_mask [2];
  lsq_pkg::byte_en_t           bgn_ben [2];
  lsq_pkg::byte_en_t           end_ben [2];
  lsq_pkg::lane_data_t         lane_data [2];

  // port registers
  logic [1:0]                  en_reg;
  lsq_pkg::store_addr_u        addr_reg [2];
  logic [lsq_pkg::BANK_W-1:0]  bank_bgn_reg [2];
  logic [lsq_pkg::BANK_W-1:0]  bank_end_reg [2];
  lsq_pkg::byte_en_t           bgn_ben_reg [2];
  lsq_pkg::byte_en_t           end_ben_reg [2];
  lsq_pkg::lane_data_t         data_reg [2];

  for (genvar g = 0; g < 2; g++) begin : g_slot
    bank_enables u_bank_enables (
      .addr      (head_addr[g]),
      .size      (head_size[g]),
      .bank_bgn  (bank_bgn[g]),
      .bank_end  (bank_end[g]),
      .bank_mask (bank_mask[g]),
      .bgn_ben   (bgn_ben[g]),
      .end_ben   (end_ben[g])
    );

    store_data_align u_store_data_align (
      .data      (head_data[g]),
      .addr      (head_addr[g]),
      .lane_data (lane_data[g])
    );
  end

  // second store only beside the first and on other banks
  assign issue[0] = head_valid[0] & ~hold_reg;
  assign issue[1] = issue[0] & head_valid[1] & ~|(bank_mask[0] & bank_mask[1]);
  assign pop_cnt  = issue[1] ? 2'd2 : {1'b0, issue[0]};

  always_ff @(posedge clk) begin
    if (reset) begin
      hold_reg <= 1'b0;
      en_reg   <= '0;
    end else begin
      hold_reg <= cache_hold;
      en_reg   <= issue;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      addr_reg[i]     <= head_addr[i];
      bank_bgn_reg[i] <= bank_bgn[i];
      bank_end_reg[i] <= bank_end[i];
      bgn_ben_reg[i]  <= bgn_ben[i];
      end_ben_reg[i]  <= end_ben[i];
      data_reg[i]     <= lane_data[i];
    end
  end

  assign st0_en       = en_reg[0];
  assign st0_addr     = addr_reg[0];
  assign st0_bank_bgn = bank_bgn_reg[0];
  assign st0_bank_end = bank_end_reg[0];
  assign st0_bgn_ben  = bgn_ben_reg[0];
  assign st0_end_ben  = end_ben_reg[0];
  assign st0_data     = data_reg[0];

  assign st1_en       = en_reg[1];
  assign st1_addr     = addr_reg[1];
  assign st1_bank_bgn = bank_bgn_reg[1];
  assign st1_bank_end = bank_end_reg[1];
  assign st1_bgn_ben  = bgn_ben_reg[1];
  assign st1_end_ben  = end_ben_reg[1];
  assign st1_data     = data_reg[1];

endmodule

// ==== logic/store_unit.sv ====
module store_unit #(
  parameter int STQ_DEPTH = 16,
  localparam int TAG_W = $clog2(STQ_DEPTH)
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              sta_en,
  input  lsq_pkg::store_addr_u              sta_addr,
  input  lsq_pkg::size_t                    sta_size,
  input  logic                              std_en,
  input  logic [TAG_W-1:0]                  std_tag,
  input  lsq_pkg::store_data_t              std_data,
  input  logic                              cache_hold,
  output logic [TAG_W-1:0]                  alloc_tag,
  output logic                              stq_full,
  output logic                              st0_en,
  output lsq_pkg::store_addr_u              st0_addr,
  output logic [lsq_pkg::BANK_W-1:0]        st0_bank_bgn,
  output logic [lsq_pkg::BANK_W-1:0]        st0_bank_end,
  output lsq_pkg::byte_en_t                 st0_bgn_ben,
  output lsq_pkg::byte_en_t                 st0_end_ben,
  output lsq_pkg::lane_data_t               st0_data,
  output logic                              st1_en,
  output lsq_pkg::store_addr_u              st1_addr,
  output logic [lsq_pkg::BANK_W-1:0]        st1_bank_bgn,
  output logic [lsq_pkg::BANK_W-1:0]        st1_bank_end,
  output lsq_pkg::byte_en_t                 st1_bgn_ben,
  output lsq_pkg::byte_en_t                 st1_end_ben,
  output lsq_pkg::lane_data_t               st1_data
);

  // queue head, oldest first
  logic [1:0]                  head_valid;
  lsq_pkg::store_addr_u [1:0]  head_addr;
  lsq_pkg::size_t [1:0]        head_size;
  lsq_pkg::store_data_t [1:0]  head_data;
  logic [1:0]                  pop_cnt;

  store_queue #(
    .STQ_DEPTH (STQ_DEPTH)
  ) u_store_queue (
    .clk        (clk),
    .reset      (reset),
    .sta_en     (sta_en),
    .sta_addr   (sta_addr),
    .sta_size   (sta_size),
    .std_en     (std_en),
    .std_tag    (std_tag),
    .std_data   (std_data),
    .pop_cnt    (pop_cnt),
    .alloc_tag  (alloc_tag),
    .stq_full   (stq_full),
    .head_valid (head_valid),
    .head_addr  (head_addr),
    .head_size  (head_size),
    .head_data  (head_data)
  );

  store_issue u_store_issue (
    .clk          (clk),
    .reset        (reset),
    .cache_hold   (cache_hold),
    .head_valid   (head_valid),
    .head_addr    (head_addr),
    .head_size    (head_size),
    .head_data    (head_data),
    .pop_cnt      (pop_cnt),
    .st0_en       (st0_en),
    .st0_addr     (st0_addr),
    .st0_bank_bgn (st0_bank_bgn),
    .st0_bank_end (st0_bank_end),
    .st0_bgn_ben  (st0_bgn_ben),
    .st0_end_ben  (st0_end_ben),
    .st0_data     (st0_data),
    .st1_en       (st1_en),
    .st1_addr     (st1_addr),
    .st1_bank_bgn (st1_bank_bgn),
    .st1_bank_end (st1_bank_end),
    .st1_bgn_ben  (st1_bgn_ben),
    .st1_end_ben  (st1_end_ben),
    .st1_data     (st1_data)
  );

endmodule

// ==== testbench/store_unit_tb.sv ====
module store_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int STQ_DEPTH    = 16;
  localparam int TAG_W        = $clog2(STQ_DEPTH);
  localparam int RESET_CYCLES = 10;
  localparam int RAND_CYCLES  = 2000;
  localparam int LANE_CYCLES  = 400;
  localparam int STIM_CYCLES  = RESET_CYCLES + RAND_CYCLES + LANE_CYCLES + 8 * STQ_DEPTH;
  localparam int CYCLE_LIMIT  = 4 * STIM_CYCLES;

  typedef logic [lsq_pkg::LANE_W-1:0] word_t;
  typedef logic [lsq_pkg::BANK_W-1:0] bank_t;
  typedef logic [TAG_W-1:0]           tag_t;

  logic                 clk;
  logic                 reset;
  logic                 sta_en;
  lsq_pkg::store_addr_u sta_addr;
  lsq_pkg::size_t       sta_size;
  logic                 std_en;
  tag_t                 std_tag;
  lsq_pkg::store_data_t std_data;
  logic                 cache_hold;
  tag_t                 alloc_tag;
  logic                 stq_full;
  logic                 st0_en;
  lsq_pkg::store_addr_u st0_addr;
  bank_t                st0_bank_bgn;
  bank_t                st0_bank_end;
  lsq_pkg::byte_en_t    st0_bgn_ben;
  lsq_pkg::byte_en_t    st0_end_ben;
  lsq_pkg::lane_data_t  st0_data;
  logic                 st1_en;
  lsq_pkg::store_addr_u st1_addr;
  bank_t                st1_bank_bgn;
  bank_t                st1_bank_end;
  lsq_pkg::byte_en_t    st1_bgn_ben;
  lsq_pkg::byte_en_t    st1_end_ben;
  lsq_pkg::lane_data_t  st1_data;

  // model queues with the oldest store first
  lsq_pkg::store_addr_u exp_addr [$];
  lsq_pkg::size_t       exp_size [$];
  lsq_pkg::store_data_t exp_data [$];
  lsq_pkg::store_data_t tag_data [STQ_DEPTH];
  tag_t                 pend_tag [$];  // allocated but data not yet sent
  tag_t                 next_tag;

  logic [31:0] rng_state;
  logic        hold_q1;
  logic        hold_q2;
  int          cycle_cnt;
  int          error_count;
  int          failed_tests;
  int          alloc_cnt;
  int          issue_cnt;
  int          dual_cnt;

  store_unit u_store_unit (
    .clk          (clk),
    .reset        (reset),
    .sta_en       (sta_en),
    .sta_addr     (sta_addr),
    .sta_size     (sta_size),
    .std_en       (std_en),
    .std_tag      (std_tag),
    .std_data     (std_data),
    .cache_hold   (cache_hold),
    .alloc_tag    (alloc_tag),
    .stq_full     (stq_full),
    .st0_en       (st0_en),
    .st0_addr     (st0_addr),
    .st0_bank_bgn (st0_bank_bgn),
    .st0_bank_end (st0_bank_end),
    .st0_bgn_ben  (st0_bgn_ben),
    .st0_end_ben  (st0_end_ben),
    .st0_data     (st0_data),
    .st1_en       (st1_en),
    .st1_addr     (st1_addr),
    .st1_bank_bgn (st1_bank_bgn),
    .st1_bank_end (st1_bank_end),
    .st1_bgn_ben  (st1_bgn_ben),
    .st1_end_ben  (st1_end_ben),
    .st1_data     (st1_data)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // walk the store byte by byte with banks wrapping mod 8
  task automatic expect_banks(input lsq_pkg::store_addr_u a, input lsq_pkg::size_t sz,
                              output bank_t bbgn, output bank_t bend,
                              output lsq_pkg::byte_en_t bben, output lsq_pkg::byte_en_t eben,
                              output lsq_pkg::bank_mask_t mask);
    int nbytes;
    int span;
    int p;
    nbytes = 1 << sz;
    span   = (int'(a.fld.ofs) + nbytes - 1) / lsq_pkg::BANK_BYTES;
    bbgn   = a.fld.bank;
    bend   = bank_t'((int'(a.fld.bank) + span) % lsq_pkg::BANKS);
    bben   = '0;
    eben   = '0;
    mask   = '0;
    for (int i = 0; i < nbytes; i++) begin
      p = int'(a.fld.ofs) + i;
      if (p / lsq_pkg::BANK_BYTES == 0) bben[p % lsq_pkg::BANK_BYTES] = 1'b1;
      if (p / lsq_pkg::BANK_BYTES == span) eben[p % lsq_pkg::BANK_BYTES] = 1'b1;
      mask[(int'(a.fld.bank) + p / lsq_pkg::BANK_BYTES) % lsq_pkg::BANKS] = 1'b1;
    end
  endtask

  function automatic lsq_pkg::lane_data_t expect_lanes(input lsq_pkg::store_data_t d,
                                                       input lsq_pkg::store_addr_u a);
    lsq_pkg::lane_data_t w;
    w = lsq_pkg::lane_data_t'(d);
    return w << (8 * a.fld.ofs);
  endfunction

  task automatic check_port(input int port, input lsq_pkg::store_addr_u addr,
                            input bank_t bbgn, input bank_t bend,
                            input lsq_pkg::byte_en_t bben, input lsq_pkg::byte_en_t eben,
                            input lsq_pkg::lane_data_t data,
                            output lsq_pkg::bank_mask_t mask);
    lsq_pkg::store_addr_u ea;
    lsq_pkg::size_t       es;
    lsq_pkg::store_data_t ed;
    bank_t                xbgn;
    bank_t                xend;
    lsq_pkg::byte_en_t    xbben;
    lsq_pkg::byte_en_t    xeben;
    mask = '0;
    issue_cnt++;  // every store seen on a port
    if (exp_addr.size() == 0) begin
      note_failure($sformatf("port %0d issued a store that was never allocated", port));
      return;
    end
    ea = exp_addr.pop_front();
    es = exp_size.pop_front();
    ed = exp_data.pop_front();
    expect_banks(ea, es, xbgn, xend, xbben, xeben, mask);
    check(word_t'(addr), word_t'(ea), $sformatf("port %0d address", port));
    check(word_t'(bbgn), word_t'(xbgn), $sformatf("port %0d bank_bgn", port));
    check(word_t'(bend), word_t'(xend), $sformatf("port %0d bank_end", port));
    check(word_t'(bben), word_t'(xbben), $sformatf("port %0d bgn_ben", port));
    check(word_t'(eben), word_t'(xeben), $sformatf("port %0d end_ben", port));
    check(word_t'(data), word_t'(expect_lanes(ed, ea)), $sformatf("port %0d data", port));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
    sta_en = 1'b0;
    std_en = 1'b0;
  endtask

  task automatic alloc_store(input lsq_pkg::store_addr_u a, input lsq_pkg::size_t sz);
    lsq_pkg::store_data_t d;
    d        = {xorshift32(), xorshift32()};
    sta_en   = 1'b1;
    sta_addr = a;
    sta_size = sz;
    if (!stq_full) begin  // a full queue drops it
      check(word_t'(alloc_tag), word_t'(next_tag), "allocation tag");
      tag_data[next_tag] = d;
      pend_tag.push_back(next_tag);
      exp_addr.push_back(a);
      exp_size.push_back(sz);
      exp_data.push_back(d);
      next_tag = next_tag + tag_t'(1);
      alloc_cnt++;
    end
  endtask

  task automatic alloc_random();
    lsq_pkg::store_addr_u a;
    logic [31:0]          r;
    a.byte_addr = xorshift32();
    r = xorshift32();
    alloc_store(a, r[1:0]);
  endtask

  task automatic write_pending();
    int   idx;
    tag_t t;
    if (pend_tag.size() != 0) begin
      idx = int'(xorshift32() % 32'(pend_tag.size()));
      t   = pend_tag[idx];
      pend_tag.delete(idx);
      std_en   = 1'b1;
      std_tag  = t;
      std_data = tag_data[t];
    end
  endtask

  task automatic drain_queue();
    cache_hold = 1'b0;
    while (exp_addr.size() != 0) begin
      next_cycle();
      write_pending();
    end
    repeat (4) next_cycle();  // nothing more may come out
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail, %0d problems", name, error_count - errs_before);
      failed_tests++;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      hold_q1 <= 1'b0;
      hold_q2 <= 1'b0;
    end else begin
      hold_q1 <= cache_hold;
      hold_q2 <= hold_q1;
    end
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin : port_monitor
    lsq_pkg::bank_mask_t mask0;
    lsq_pkg::bank_mask_t mask1;
    if (!reset) begin
      if (hold_q2 && st0_en) note_failure("store issued right after cache_hold was sampled high");
      if (st1_en && !st0_en) note_failure("port 1 issued without port 0");
      if (st0_en) begin
        check_port(0, st0_addr, st0_bank_bgn, st0_bank_end, st0_bgn_ben, st0_end_ben,
                   st0_data, mask0);
      end
      if (st1_en) begin
        check_port(1, st1_addr, st1_bank_bgn, st1_bank_end, st1_bgn_ben, st1_end_ben,
                   st1_data, mask1);
        if (st0_en) begin
          dual_cnt++;
          if ((mask0 & mask1) != '0) note_failure("ports 0 and 1 write the same bank");
        end
      end
    end
  end

  initial begin : main
    lsq_pkg::store_addr_u a;
    logic [31:0]          r;
    int                   errs;
    int                   duals;
    clk          = 1'b0;
    reset        = 1'b1;
    sta_en       = 1'b0;
    sta_addr     = '0;
    sta_size     = '0;
    std_en       = 1'b0;
    std_tag      = '0;
    std_data     = '0;
    cache_hold   = 1'b0;
    rng_state    = 32'ha1df_fffb;
    next_tag     = '0;
    cycle_cnt    = 0;
    error_count  = 0;
    failed_tests = 0;
    alloc_cnt    = 0;
    issue_cnt    = 0;
    dual_cnt     = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;

    // random traffic with random hold
    errs = error_count;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      next_cycle();
      r = xorshift32();
      if (r[2:0] < 3'd5) write_pending();
      if (r[5:3] < 3'd5) alloc_random();
      cache_hold = r[10:8] < 3'd2;
    end
    drain_queue();
    check(word_t'(issue_cnt), word_t'(alloc_cnt), "stores issued against stores allocated");
    finish_test("1 order and completeness", errs);

    // 1 byte, aligned word, 8 bytes at offset 3 wrapping past bank 7
    errs = error_count;
    a.byte_addr = 32'h0000_1009;
    next_cycle();
    alloc_store(a, 2'd0);
    a.byte_addr = 32'h0000_2014;
    next_cycle();
    alloc_store(a, 2'd2);
    a.byte_addr = 32'h0000_301f;
    next_cycle();
    alloc_store(a, 2'd3);
    drain_queue();
    finish_test("2 bank fields", errs);

    errs = error_count;
    for (int c = 0; c < LANE_CYCLES; c++) begin
      next_cycle();
      write_pending();
      alloc_random();
    end
    drain_queue();
    finish_test("3 data lanes", errs);

    // one byte per bank and all ready before the hold drops
    errs  = error_count;
    duals = dual_cnt;
    cache_hold = 1'b1;
    for (int i = 0; i < lsq_pkg::BANKS; i++) begin
      next_cycle();
      write_pending();
      a.byte_addr = xorshift32();
      a.fld.bank  = bank_t'(i);
      alloc_store(a, 2'd0);
    end
    while (pend_tag.size() != 0) begin
      next_cycle();
      write_pending();
    end
    repeat (2) next_cycle();
    drain_queue();
    if (dual_cnt == duals) note_failure("no dual issue seen with stores in disjoint banks");
    finish_test("4 dual issue", errs);

    errs = error_count;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      next_cycle();
      check(word_t'(stq_full), word_t'(0), "stq_full before the queue is full");
      alloc_random();
    end
    next_cycle();
    check(word_t'(stq_full), word_t'(1), "stq_full after depth allocations");
    alloc_random();
    next_cycle();
    check(word_t'(stq_full), word_t'(1), "stq_full after an ignored allocation");
    cache_hold = 1'b1;
    while (pend_tag.size() != 0) begin
      next_cycle();
      write_pending();
    end
    repeat (3) next_cycle();
    check(word_t'(issue_cnt), word_t'(alloc_cnt - STQ_DEPTH), "stores issued under hold");
    drain_queue();
    finish_test("5 hold and full", errs);

    $display("tests run 5, tests failed %0d, problems %0d, dual issues %0d",
             failed_tests, error_count, dual_cnt);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
logic/lsq_pkg.sv
logic/store_queue.sv
logic/bank_enables.sv
logic/store_data_align.sv
logic/store_issue.sv
logic/store_unit.sv
testbench/store_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module store_unit_tb -f flist.f -o store_unit_sim
output=$(./obj_dir/store_unit_sim)
echo "$output"

if grep -qx "NO ERRORS" <<< "$output"; then
  exit 0
fi
echo "simulation failed"
exit 1
